// ==== filelist.f ====
design/bus_pkg.sv
design/soc_map_pkg.sv
design/bus_if.sv
design/bus.sv
design/ram_device.sv
design/reg_device.sv
design/bus_subsys_top.sv
verif/tb_bus_subsys.sv

// ==== Bender.yml ====
package:
  name: bus_subsys

sources:
  # Design sources in compile order
  - files:
      - design/bus_pkg.sv
      - design/soc_map_pkg.sv
      - design/bus_if.sv
      - design/bus.sv
      - design/ram_device.sv
      - design/reg_device.sv
      - design/bus_subsys_top.sv

  # Testbench
  - target: test
    files:
      - verif/tb_bus_subsys.sv

// ==== verif/tb_bus_subsys.sv ====
// Directed testbench for the two-host bus subsystem
// Hosts are played here; expected values come from a shadow model of RAM and registers
`timescale 1ns/10ps

module tb_bus_subsys
  import bus_pkg::*;
  import soc_map_pkg::*;
();

  localparam logic [31:0] LfsrSeed      = 32'h01f2_b119;
  localparam int          TimeoutCycles = 20;

  logic        clk;
  logic        rst_n;
  logic [1:0]  req;
  logic [1:0]  gnt;
  logic [1:0]  we;
  logic [1:0]  rvalid;
  logic [1:0]  err;
  addr_t       addr  [2];
  be_t         be    [2];
  data_t       wdata [2];
  data_t       rdata [2];

  logic [31:0] lfsr_q;
  data_t       ram_model [RamWords];
  data_t       scratch_model [2];

  bus_subsys_top u_dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .host0_req_i    (req[0]),
    .host0_gnt_o    (gnt[0]),
    .host0_addr_i   (addr[0]),
    .host0_we_i     (we[0]),
    .host0_be_i     (be[0]),
    .host0_wdata_i  (wdata[0]),
    .host0_rvalid_o (rvalid[0]),
    .host0_rdata_o  (rdata[0]),
    .host0_err_o    (err[0]),
    .host1_req_i    (req[1]),
    .host1_gnt_o    (gnt[1]),
    .host1_addr_i   (addr[1]),
    .host1_we_i     (we[1]),
    .host1_be_i     (be[1]),
    .host1_wdata_i  (wdata[1]),
    .host1_rvalid_o (rvalid[1]),
    .host1_rdata_o  (rdata[1]),
    .host1_err_o    (err[1])
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t en);
    data_t res;
    res = old_w;
    for (int b = 0; b < BeWidth; b++) begin
      if (en[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic addr_t ram_addr(input int idx);
    return RamBase + addr_t'(idx) * 4;
  endfunction

  function automatic addr_t reg_addr(input int off);
    return RegBase + addr_t'(off) * 4;
  endfunction

  task automatic check_data(input data_t got, input data_t exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      $display("Checks failed");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
      $display("Checks failed");
      $fatal(1, "bit mismatch");
    end
  endtask

  task automatic report_timeout(input string what, input int h);
    $display("Timed out at %0t ns waiting for %s on host %0d", $time, what, h);
    $display("Checks failed");
    $fatal(1, "timeout");
  endtask

  // One request on host h, held until gnt, then the response is collected
  task automatic host_access(input int h, input logic wr, input addr_t a, input be_t en,
                             input data_t wd, output data_t rd, output logic er,
                             output int gnt_wait);
    int resp_wait;
    @(posedge clk);
    #1;
    req[h]   = 1'b1;
    we[h]    = wr;
    addr[h]  = a;
    be[h]    = en;
    wdata[h] = wd;
    gnt_wait = 0;
    @(negedge clk);
    while (!gnt[h]) begin
      if (gnt_wait == TimeoutCycles) report_timeout("gnt", h);
      else begin
        gnt_wait++;
        @(negedge clk);
      end
    end
    @(posedge clk);
    #1;
    req[h]    = 1'b0;
    resp_wait = 0;
    @(negedge clk);
    while (!rvalid[h]) begin
      if (resp_wait == TimeoutCycles) report_timeout("rvalid", h);
      else begin
        resp_wait++;
        @(negedge clk);
      end
    end
    rd = rdata[h];
    er = err[h];
    check_bit(resp_wait == 0, 1'b1, "rvalid one cycle after gnt");
  endtask

  task automatic access_check(input int h, input logic wr, input addr_t a, input be_t en,
                              input data_t wd, input data_t exp_rd, input logic exp_er);
    data_t rd;
    logic  er;
    int    gw;
    host_access(h, wr, a, en, wd, rd, er, gw);
    check_bit(er, exp_er, "err response");
    if (!wr && !exp_er) check_data(rd, exp_rd, "read data");
  endtask

  task automatic test_reset_state();
    for (int h = 0; h < 2; h++) begin
      check_bit(gnt[h], 1'b0, "gnt low after reset");
      check_bit(rvalid[h], 1'b0, "rvalid low after reset");
      check_bit(err[h], 1'b0, "err low after reset");
    end
  endtask

  task automatic test_ram();
    int    idx_q[$];
    int    idx;
    data_t wd;
    be_t   en;
    for (int i = 0; i < 8; i++) begin
      idx = int'(rand_bits(8));
      wd  = rand_bits(32);
      ram_model[idx] = wd;
      idx_q.push_back(idx);
      access_check(i % 2, 1'b1, ram_addr(idx), 4'hf, wd, '0, 1'b0);
    end
    // Read back through the other host
    for (int i = 0; i < idx_q.size(); i++) begin
      access_check((i + 1) % 2, 1'b0, ram_addr(idx_q[i]), '0, '0, ram_model[idx_q[i]], 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      idx = idx_q[i];
      en  = be_t'(rand_bits(4));
      if (en == '0 || en == '1) en = 4'b0110;
      wd  = rand_bits(32);
      ram_model[idx] = merge_bytes(ram_model[idx], wd, en);
      access_check(i % 2, 1'b1, ram_addr(idx), en, wd, '0, 1'b0);
      access_check(1, 1'b0, ram_addr(idx), '0, '0, ram_model[idx], 1'b0);
    end
  endtask

  task automatic test_regs();
    data_t wd;
    be_t   en;
    access_check(0, 1'b0, reg_addr(RegOffScratch0), '0, '0, 32'h0, 1'b0);
    access_check(1, 1'b0, reg_addr(RegOffScratch1), '0, '0, 32'h0, 1'b0);
    access_check(0, 1'b0, reg_addr(RegOffId), '0, '0, RegIdValue, 1'b0);
    wd = rand_bits(32);
    scratch_model[0] = wd;
    access_check(0, 1'b1, reg_addr(RegOffScratch0), 4'hf, wd, '0, 1'b0);
    wd = rand_bits(32);
    en = 4'b1001;
    scratch_model[1] = merge_bytes(scratch_model[1], wd, en);
    access_check(1, 1'b1, reg_addr(RegOffScratch1), en, wd, '0, 1'b0);
    access_check(1, 1'b0, reg_addr(RegOffScratch0), '0, '0, scratch_model[0], 1'b0);
    access_check(0, 1'b0, reg_addr(RegOffScratch1), '0, '0, scratch_model[1], 1'b0);
    // Illegal accesses leave the registers alone
    access_check(0, 1'b1, reg_addr(RegOffId), 4'hf, rand_bits(32), '0, 1'b1);
    access_check(1, 1'b0, reg_addr(RegOffId), '0, '0, RegIdValue, 1'b0);
    access_check(0, 1'b0, reg_addr(3), '0, '0, '0, 1'b1);
    access_check(1, 1'b1, reg_addr(3), 4'hf, rand_bits(32), '0, 1'b1);
    access_check(0, 1'b0, reg_addr(RegOffScratch0), '0, '0, scratch_model[0], 1'b0);
    access_check(0, 1'b0, reg_addr(RegOffScratch1), '0, '0, scratch_model[1], 1'b0);
  endtask

  task automatic test_unmapped();
    ram_model[0] = rand_bits(32);
    access_check(0, 1'b1, ram_addr(0), 4'hf, ram_model[0], '0, 1'b0);
    access_check(1, 1'b1, 32'h0002_0000, 4'hf, rand_bits(32), '0, 1'b1);
    access_check(0, 1'b0, 32'h0002_0000, '0, '0, '0, 1'b1);
    access_check(1, 1'b1, 32'h0000_0400, 4'hf, rand_bits(32), '0, 1'b1);
    access_check(0, 1'b1, 32'h0001_0010, 4'hf, rand_bits(32), '0, 1'b1);
    access_check(1, 1'b0, ram_addr(0), '0, '0, ram_model[0], 1'b0);
    access_check(0, 1'b0, reg_addr(RegOffScratch0), '0, '0, scratch_model[0], 1'b0);
  endtask

  task automatic test_arbitration();
    data_t rd0;
    data_t rd1;
    logic  er0;
    logic  er1;
    int    gw0;
    int    gw1;
    ram_model[10] = rand_bits(32);
    ram_model[20] = rand_bits(32);
    access_check(0, 1'b1, ram_addr(10), 4'hf, ram_model[10], '0, 1'b0);
    access_check(1, 1'b1, ram_addr(20), 4'hf, ram_model[20], '0, 1'b0);
    fork
      host_access(0, 1'b0, ram_addr(10), '0, '0, rd0, er0, gw0);
      host_access(1, 1'b0, ram_addr(20), '0, '0, rd1, er1, gw1);
    join
    check_bit(gw0 == 0, 1'b1, "host 0 granted at once");
    check_bit(gw1 == 1, 1'b1, "host 1 granted one cycle later");
    check_data(rd0, ram_model[10], "host 0 own response");
    check_data(rd1, ram_model[20], "host 1 own response");
    check_bit(er0 | er1, 1'b0, "no err in arbitration");
  endtask

  task automatic test_pipeline();
    int idx [4];
    for (int k = 0; k < 4; k++) begin
      idx[k] = 40 + 3 * k;
      ram_model[idx[k]] = rand_bits(32);
      access_check(k % 2, 1'b1, ram_addr(idx[k]), 4'hf, ram_model[idx[k]], '0, 1'b0);
    end
    @(posedge clk);
    #1;
    req[0]  = 1'b1;
    we[0]   = 1'b0;
    addr[0] = ram_addr(idx[0]);
    for (int k = 0; k < 4; k++) begin
      @(negedge clk);
      check_bit(gnt[0], 1'b1, "back-to-back gnt");
      check_bit(rvalid[0], k > 0, "rvalid in step with grants");
      if (k > 0) check_data(rdata[0], ram_model[idx[k-1]], "pipelined read data");
      @(posedge clk);
      #1;
      if (k < 3) addr[0] = ram_addr(idx[k+1]);
      else req[0] = 1'b0;
    end
    @(negedge clk);
    check_bit(rvalid[0], 1'b1, "last pipelined rvalid");
    check_data(rdata[0], ram_model[idx[3]], "last pipelined read data");
    @(negedge clk);
    check_bit(rvalid[0], 1'b0, "no extra rvalid");
  endtask

  initial begin
    lfsr_q = LfsrSeed;
    rst_n  = 1'b0;
    req    = '0;
    we     = '0;
    for (int h = 0; h < 2; h++) begin
      addr[h]  = '0;
      be[h]    = '0;
      wdata[h] = '0;
    end
    scratch_model[0] = '0;
    scratch_model[1] = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    test_reset_state();
    test_regs();
    test_ram();
    test_unmapped();
    test_arbitration();
    test_pipeline();
    $display("All checks passed");
    $finish;
  end

endmodule

// ==== design/bus_subsys_top.sv ====
// Two-host bus subsystem with RAM and register block
// Hosts hold their request until gnt; the response comes one cycle after gnt
`timescale 1ns/10ps

module bus_subsys_top
  import bus_pkg::*;
  import soc_map_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,

  // Host 0, highest priority
  input  logic  host0_req_i,
  output logic  host0_gnt_o,
  input  addr_t host0_addr_i,
  input  logic  host0_we_i,
  input  be_t   host0_be_i,
  input  data_t host0_wdata_i,
  output logic  host0_rvalid_o,
  output data_t host0_rdata_o,
  output logic  host0_err_o,

  // Host 1
  input  logic  host1_req_i,
  output logic  host1_gnt_o,
  input  addr_t host1_addr_i,
  input  logic  host1_we_i,
  input  be_t   host1_be_i,
  input  data_t host1_wdata_i,
  output logic  host1_rvalid_o,
  output data_t host1_rdata_o,
  output logic  host1_err_o
);

  bus_if host_if [NrHosts] ();
  bus_if dev_if  [NrDevices] ();

  assign host_if[0].req   = host0_req_i;
  assign host_if[0].addr  = host0_addr_i;
  assign host_if[0].we    = host0_we_i;
  assign host_if[0].be    = host0_be_i;
  assign host_if[0].wdata = host0_wdata_i;
  assign host0_gnt_o      = host_if[0].gnt;
  assign host0_rvalid_o   = host_if[0].rvalid;
  assign host0_rdata_o    = host_if[0].rdata;
  assign host0_err_o      = host_if[0].err;

  assign host_if[1].req   = host1_req_i;
  assign host_if[1].addr  = host1_addr_i;
  assign host_if[1].we    = host1_we_i;
  assign host_if[1].be    = host1_be_i;
  assign host_if[1].wdata = host1_wdata_i;
  assign host1_gnt_o      = host_if[1].gnt;
  assign host1_rvalid_o   = host_if[1].rvalid;
  assign host1_rdata_o    = host_if[1].rdata;
  assign host1_err_o      = host_if[1].err;

  bus u_bus (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .host_ch (host_if),
    .dev_ch  (dev_if)
  );

  ram_device u_ram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .ch     (dev_if[DevRam])
  );

  reg_device u_reg (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .ch     (dev_if[DevReg])
  );

endmodule

// ==== design/reg_device.sv ====
// Register block with two scratch words and a read-only ID
// Writing ID or touching offset 3 returns err and changes nothing
`timescale 1ns/10ps

module reg_device
  import bus_pkg::*;
  import soc_map_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  bus_if.device ch
);

  logic [1:0] offset;
  logic       bad_access;
  data_t      scratch0_q;
  data_t      scratch1_q;
  data_t      rdata_q;
  data_t      read_word;
  logic       rvalid_q;
  logic       err_q;

  // Word offset inside the 16-byte window
  assign offset = ch.addr[3:2];

  // ID is read-only and offset 3 has no register
  assign bad_access = (ch.we && offset == RegOffId) ||
                      !(offset inside {RegOffScratch0, RegOffScratch1, RegOffId});

  always_comb begin
    case (offset)
      RegOffScratch0: read_word = scratch0_q;
      RegOffScratch1: read_word = scratch1_q;
      RegOffId:       read_word = RegIdValue;
      default:        read_word = '0;
    endcase
  end

  // Scratch registers with byte enables
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scratch0_q <= '0;
      scratch1_q <= '0;
    end else if (ch.req && ch.we && !bad_access) begin
      for (int b = 0; b < BeWidth; b++) begin
        if (ch.be[b]) begin
          if (offset == RegOffScratch0) begin
            scratch0_q[8*b +: 8] <= ch.wdata[8*b +: 8];
          end else if (offset == RegOffScratch1) begin
            scratch1_q[8*b +: 8] <= ch.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Read data only captured on reads
  always_ff @(posedge clk_i) begin
    if (ch.req && !ch.we) begin
      rdata_q <= read_word;
    end
  end

  // Response flags one cycle after the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= ch.req;
      err_q    <= ch.req && bad_access;
    end
  end

  // Always accepts
  assign ch.gnt    = ch.req;
  assign ch.rvalid = rvalid_q;
  assign ch.rdata  = rdata_q;
  assign ch.err    = err_q;

  // Only addresses inside this block's window may reach it
  a_req_in_window : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ch.req |-> ((ch.addr & RegMask) == RegBase));

endmodule

// ==== design/ram_device.sv ====
// Word RAM, RamWords deep, indexed by address bits above the byte offset
// Contents are not cleared by reset; err is never raised
`timescale 1ns/10ps

module ram_device
  import bus_pkg::*;
  import soc_map_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  bus_if.device ch
);

  data_t                       mem [RamWords];
  logic [$clog2(RamWords)-1:0] word_idx;
  data_t                       rdata_q;
  logic                        rvalid_q;

  // Word select, byte offset dropped
  assign word_idx = ch.addr[$clog2(RamWords)+1:2];

  // Byte-enabled write or registered read
  always_ff @(posedge clk_i) begin
    if (ch.req) begin
      if (ch.we) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (ch.be[b]) begin
            mem[word_idx][8*b +: 8] <= ch.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  // One-cycle response strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= ch.req;
    end
  end

  // Always accepts
  assign ch.gnt    = ch.req;
  assign ch.rvalid = rvalid_q;
  assign ch.rdata  = rdata_q;
  assign ch.err    = 1'b0;

  // A write with no bytes enabled is a host bug
  a_write_has_be : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ch.req && ch.we) |-> (ch.be != '0));

endmodule

// ==== design/bus.sv ====
// Fixed-priority bus fabric in which host 0 always wins and there is no fairness
// Devices must answer in the cycle after their request and have no wait states
// Unmapped addresses are answered by the fabric with err
`timescale 1ns/10ps

module bus
  import bus_pkg::*;
  import soc_map_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  bus_if.device host_ch [NrHosts],
  bus_if.host   dev_ch  [NrDevices]
);

  // Host side copies
  logic [NrHosts-1:0] h_req;
  logic [NrHosts-1:0] h_gnt;
  addr_t              h_addr  [NrHosts];
  logic               h_we    [NrHosts];
  be_t                h_be    [NrHosts];
  data_t              h_wdata [NrHosts];

  // Device response copies
  logic               d_rvalid [NrDevices];
  data_t              d_rdata  [NrDevices];
  logic               d_err    [NrDevices];

  // Address phase
  logic               any_req;
  logic               hit;
  host_idx_t          sel_host;
  dev_idx_t           sel_dev;
  addr_t              sel_addr;
  logic               sel_we;
  be_t                sel_be;
  data_t              sel_wdata;
  logic [NrDevices-1:0] fwd;

  // Response phase
  host_idx_t          resp_host_q;
  dev_idx_t           resp_dev_q;
  logic               resp_miss_q;
  logic               resp_active;

  // Lowest index wins
  always_comb begin
    any_req  = |h_req;
    sel_host = '0;
    for (int h = NrHosts - 1; h >= 0; h--) begin
      if (h_req[h]) begin
        sel_host = host_idx_t'(h);
      end
    end
    h_gnt = '0;
    if (any_req) begin
      h_gnt[sel_host] = 1'b1;
    end
  end

  assign sel_addr  = h_addr[sel_host];
  assign sel_we    = h_we[sel_host];
  assign sel_be    = h_be[sel_host];
  assign sel_wdata = h_wdata[sel_host];

  // Base/mask decode of the winning address
  always_comb begin
    hit     = 1'b0;
    sel_dev = DevRam;
    if ((sel_addr & RamMask) == RamBase) begin
      hit     = 1'b1;
      sel_dev = DevRam;
    end else if ((sel_addr & RegMask) == RegBase) begin
      hit     = 1'b1;
      sel_dev = DevReg;
    end
    fwd = '0;
    if (any_req && hit) begin
      fwd[sel_dev] = 1'b1;
    end
  end

  // Remember who asked and where it went
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_host_q <= '0;
      resp_dev_q  <= '0;
      resp_miss_q <= 1'b0;
    end else begin
      resp_host_q <= sel_host;
      resp_dev_q  <= sel_dev;
      resp_miss_q <= any_req && !hit;
    end
  end

  // Fabric answers a miss on its own
  assign resp_active = resp_miss_q || d_rvalid[resp_dev_q];

  for (genvar h = 0; h < NrHosts; h++) begin : g_host
    assign h_req[h]   = host_ch[h].req;
    assign h_addr[h]  = host_ch[h].addr;
    assign h_we[h]    = host_ch[h].we;
    assign h_be[h]    = host_ch[h].be;
    assign h_wdata[h] = host_ch[h].wdata;

    assign host_ch[h].gnt    = h_gnt[h];
    assign host_ch[h].rvalid = (resp_host_q == host_idx_t'(h)) && resp_active;
    assign host_ch[h].err    = (resp_host_q == host_idx_t'(h)) &&
                               (resp_miss_q || d_err[resp_dev_q]);
    assign host_ch[h].rdata  = (resp_host_q == host_idx_t'(h)) ? d_rdata[resp_dev_q] : '0;

    // A grant is always answered on the next edge, and only then
    a_gnt_gets_rvalid : assert property (@(posedge clk_i) disable iff (!rst_ni)
      h_gnt[h] |=> host_ch[h].rvalid);
    a_rvalid_had_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
      host_ch[h].rvalid |-> $past(h_gnt[h]));
  end

  for (genvar d = 0; d < NrDevices; d++) begin : g_dev
    // Non-selected devices see an idle channel
    assign dev_ch[d].req   = fwd[d];
    assign dev_ch[d].addr  = fwd[d] ? sel_addr : '0;
    assign dev_ch[d].we    = fwd[d] ? sel_we : 1'b0;
    assign dev_ch[d].be    = fwd[d] ? sel_be : '0;
    assign dev_ch[d].wdata = fwd[d] ? sel_wdata : '0;

    assign d_rvalid[d] = dev_ch[d].rvalid;
    assign d_rdata[d]  = dev_ch[d].rdata;
    assign d_err[d]    = dev_ch[d].err;

    a_dev_rvalid_after_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
      dev_ch[d].rvalid |-> $past(dev_ch[d].req));
  end

  // Only the lowest requesting host is granted, and never more than one
  a_gnt_lowest_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    h_gnt == (h_req & -h_req));

endmodule

// ==== design/bus_if.sv ====
// One request/response channel between a host side and a device side
// req is held until gnt; rvalid pulses exactly one cycle after the grant
`timescale 1ns/10ps

interface bus_if
  import bus_pkg::*;
();

  // Request phase
  logic  req;
  logic  gnt;
  addr_t addr;
  logic  we;
  be_t   be;
  data_t wdata;

  // Response phase
  logic  rvalid;
  data_t rdata;
  logic  err;

  // Requesting side
  modport host (
    output req,
    output addr,
    output we,
    output be,
    output wdata,
    input  gnt,
    input  rvalid,
    input  rdata,
    input  err
  );

  // Answering side
  modport device (
    input  req,
    input  addr,
    input  we,
    input  be,
    input  wdata,
    output gnt,
    output rvalid,
    output rdata,
    output err
  );

endinterface

// ==== design/soc_map_pkg.sv ====
// Device address map and register block layout
// Windows must not overlap; an address outside both gets an error from the bus
package soc_map_pkg;

  import bus_pkg::*;

  // Word RAM at 0x0000_0000, 1 KiB window
  localparam addr_t RamBase = 32'h0000_0000;
  localparam addr_t RamMask = 32'hffff_fc00;

  // Register block at 0x0001_0000, 16-byte window
  localparam addr_t RegBase = 32'h0001_0000;
  localparam addr_t RegMask = 32'hffff_fff0;

  // Device slots on the fabric
  localparam dev_idx_t DevRam = dev_idx_t'(0);
  localparam dev_idx_t DevReg = dev_idx_t'(1);

  // Register block word offsets, offset 3 is unused
  localparam logic [1:0] RegOffScratch0 = 2'd0;
  localparam logic [1:0] RegOffScratch1 = 2'd1;
  localparam logic [1:0] RegOffId       = 2'd2;

  // Read-only identification word
  localparam data_t RegIdValue = 32'h0b05_0001;

  // RAM depth in words
  localparam int RamWords = 256;

endpackage

// ==== design/bus_pkg.sv ====
// Bus fabric widths and index types
// Two hosts and two devices only, so both index types are a single bit
package bus_pkg;

  // Fabric size
  localparam int NrHosts   = 2;
  localparam int NrDevices = 2;

  // Channel widths
  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;
  localparam int BeWidth   = DataWidth / 8;

  // Byte address
  typedef logic [AddrWidth-1:0] addr_t;

  // Data word
  typedef logic [DataWidth-1:0] data_t;

  // One enable bit per data byte
  typedef logic [BeWidth-1:0] be_t;

  // Host and device selects
  typedef logic [$clog2(NrHosts)-1:0]   host_idx_t;
  typedef logic [$clog2(NrDevices)-1:0] dev_idx_t;

endpackage
